// ==== verilog/ooo_pkg.sv ====
package ooo_pkg;

    localparam int xlen = 32;
    localparam int reg_addr_len = 5;
    localparam int tag_len = 4;
    localparam int lat_len = 3;

    typedef logic [xlen-1:0] data_t;
    typedef logic [reg_addr_len-1:0] reg_addr_t;
    typedef logic [tag_len-1:0] tag_t;

    typedef enum logic [1:0] {
        op_add = 2'd0,
        op_sub = 2'd1,
        op_xor = 2'd2,
        op_brc = 2'd3  // Branch compare, predicted not equal.
    } op_e;

    function automatic logic [lat_len-1:0] op_latency(op_e op);
        case (op)
            op_sub:  return 3'd3;
            op_brc:  return 3'd2;
            default: return 3'd1;
        endcase
    endfunction

    typedef struct packed {
        op_e       op;
        reg_addr_t rd;
        data_t     src_a;
        data_t     src_b;
    } instr_t;

    typedef struct packed {
        tag_t  tag;
        data_t result;
        logic  mispredict;
    } cdb_t;

    typedef struct packed {
        reg_addr_t rd;
        data_t     data;
    } commit_t;

endpackage

// ==== verilog/dispatch_unit.sv ====
`timescale 1ns/1ps

module dispatch_unit #(
    parameter int rob_depth = 8
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            instr_valid,
    input  ooo_pkg::instr_t instr,
    input  logic            rob_full,
    input  logic            station_full,
    input  logic            flush,
    input  ooo_pkg::tag_t   next_tag,
    output logic            stall,
    output logic            disp_fire,
    output ooo_pkg::tag_t   disp_tag,
    output ooo_pkg::instr_t disp_instr
);

    localparam ooo_pkg::tag_t tag_mask = ooo_pkg::tag_t'(rob_depth - 1);

    logic            accept;
    logic            fire_q;
    ooo_pkg::tag_t   alloc_tag;
    ooo_pkg::tag_t   tag_q;
    ooo_pkg::instr_t instr_q;

    assign stall = rob_full | station_full;
    assign accept = instr_valid & ~stall & ~flush;

    // The ROB tail only moves once the held instruction lands, so skip past it.
    assign alloc_tag = (next_tag + ooo_pkg::tag_t'(disp_fire)) & tag_mask;

    always_ff @(posedge clk) begin
        if (rst) begin
            fire_q <= 1'b0;
        end else begin
            fire_q <= accept;  // A flush drops the held instruction.
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            instr_q <= instr;
            tag_q <= alloc_tag;
        end
    end

    assign disp_fire = fire_q & ~flush;
    assign disp_tag = tag_q;
    assign disp_instr = instr_q;

endmodule

// ==== verilog/exec_station.sv ====
`timescale 1ns/1ps

module exec_station #(
    parameter int station_slots = 4
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            flush,
    input  logic            disp_fire,
    input  ooo_pkg::tag_t   disp_tag,
    input  ooo_pkg::instr_t disp_instr,
    output logic            station_full,
    output logic            cdb_valid,
    output ooo_pkg::cdb_t   cdb
);

    localparam int slot_len = (station_slots > 1) ? $clog2(station_slots) : 1;

    typedef struct packed {
        logic                        valid;
        ooo_pkg::instr_t             instr;
        ooo_pkg::tag_t               tag;
        logic [slot_len-1:0]         age;  // Count of younger operations held.
        logic [ooo_pkg::lat_len-1:0] remain;
    } slot_t;

    slot_t slots [station_slots];

    logic                     found;
    logic [slot_len-1:0]      sel;
    logic [slot_len-1:0]      sel_age;
    logic [station_slots-1:0] older;
    logic                     free_found;
    logic [slot_len-1:0]      free_idx;
    logic [slot_len:0]        free_cnt;
    ooo_pkg::instr_t          win;

    // Oldest finished slot wins the bus.
    always_comb begin
        found = 1'b0;
        sel = '0;
        sel_age = '0;
        for (int i = 0; i < station_slots; i++) begin
            if (slots[i].valid && slots[i].remain == '0 && (!found || slots[i].age > sel_age)) begin
                found = 1'b1;
                sel = i[slot_len-1:0];
                sel_age = slots[i].age;
            end
        end
        for (int i = 0; i < station_slots; i++) begin
            older[i] = found && slots[i].age > sel_age;
        end
    end

    always_comb begin
        free_found = 1'b0;
        free_idx = '0;
        free_cnt = '0;
        for (int i = 0; i < station_slots; i++) begin
            if (!slots[i].valid) begin
                free_cnt = free_cnt + 1'b1;
                if (!free_found) begin
                    free_found = 1'b1;
                    free_idx = i[slot_len-1:0];
                end
            end
        end
    end

    // Keeps a slot spare for the operation still in the dispatch register.
    assign station_full = free_cnt <= (slot_len + 1)'(1);

    assign win = slots[sel].instr;
    assign cdb_valid = found;

    always_comb begin
        cdb.tag = slots[sel].tag;
        cdb.mispredict = 1'b0;
        case (win.op)
            ooo_pkg::op_add: cdb.result = win.src_a + win.src_b;
            ooo_pkg::op_sub: cdb.result = win.src_a - win.src_b;
            ooo_pkg::op_xor: cdb.result = win.src_a ^ win.src_b;
            default: begin
                cdb.result = ooo_pkg::data_t'(win.src_a == win.src_b);
                cdb.mispredict = win.src_a == win.src_b;  // Predicted not equal.
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            for (int i = 0; i < station_slots; i++) begin
                slots[i].valid <= 1'b0;
            end
        end else begin
            for (int i = 0; i < station_slots; i++) begin
                if (slots[i].valid) begin
                    if (slots[i].remain != '0) begin
                        slots[i].remain <= slots[i].remain - 1'b1;
                    end
                    if (disp_fire && !older[i]) begin
                        slots[i].age <= slots[i].age + 1'b1;
                    end else if (!disp_fire && older[i]) begin
                        slots[i].age <= slots[i].age - 1'b1;
                    end
                end
            end

            if (found) begin
                slots[sel].valid <= 1'b0;
            end

            if (disp_fire && free_found) begin
                slots[free_idx].valid <= 1'b1;
                slots[free_idx].instr <= disp_instr;
                slots[free_idx].tag <= disp_tag;
                slots[free_idx].age <= '0;
                slots[free_idx].remain <= ooo_pkg::op_latency(disp_instr.op) - 1'b1;
            end
        end
    end

endmodule

// ==== verilog/reorder_buffer.sv ====
`timescale 1ns/1ps

module reorder_buffer #(
    parameter int rob_depth = 8
) (
    input  logic             clk,
    input  logic             rst,
    output logic             flush,
    input  logic             disp_fire,
    input  ooo_pkg::tag_t    disp_tag,
    input  ooo_pkg::instr_t  disp_instr,
    input  logic             cdb_valid,
    input  ooo_pkg::cdb_t    cdb,
    output ooo_pkg::tag_t    next_tag,
    output logic             rob_full,
    output logic             commit_valid,
    output ooo_pkg::commit_t commit
);

    localparam int idx_len = (rob_depth > 1) ? $clog2(rob_depth) : 1;
    // One entry of margin for the instruction held in the dispatch register.
    localparam logic [idx_len:0] full_level = (idx_len + 1)'(rob_depth - 1);

    typedef struct packed {
        logic               valid;
        logic               ready;
        logic               mispredict;
        ooo_pkg::reg_addr_t rd;
        ooo_pkg::data_t     data;
    } rob_entry_t;

    rob_entry_t entries [rob_depth];

    logic [idx_len-1:0] head;
    logic [idx_len-1:0] tail;
    logic [idx_len:0]   count;
    logic [idx_len-1:0] disp_idx;
    logic [idx_len-1:0] cdb_idx;

    assign disp_idx = disp_tag[idx_len-1:0];
    assign cdb_idx = cdb.tag[idx_len-1:0];

    assign next_tag = ooo_pkg::tag_t'(tail);
    assign rob_full = count >= full_level;

    // The head retires as soon as its result has come back on the CDB.
    assign commit_valid = entries[head].valid & entries[head].ready;
    assign commit.rd = entries[head].rd;
    assign commit.data = entries[head].data;
    assign flush = commit_valid & entries[head].mispredict;  // Branch resolved equal.

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            head <= '0;
            tail <= '0;
            count <= '0;
            for (int i = 0; i < rob_depth; i++) begin
                entries[i].valid <= 1'b0;
            end
        end else begin
            if (disp_fire) begin
                entries[disp_idx].valid <= 1'b1;
                entries[disp_idx].ready <= 1'b0;
                entries[disp_idx].mispredict <= 1'b0;
                entries[disp_idx].rd <= disp_instr.rd;
                tail <= tail + 1'b1;  // Wraps, depth is a power of two.
            end

            if (cdb_valid) begin
                entries[cdb_idx].ready <= 1'b1;
                entries[cdb_idx].data <= cdb.result;
                entries[cdb_idx].mispredict <= cdb.mispredict;
            end

            if (commit_valid) begin
                entries[head].valid <= 1'b0;
                head <= head + 1'b1;
            end

            case ({disp_fire, commit_valid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== verilog/arch_reg_file.sv ====
`timescale 1ns/1ps

module arch_reg_file (
    input  logic               clk,
    input  logic               rst,
    input  logic               commit_valid,
    input  ooo_pkg::commit_t   commit,
    input  ooo_pkg::reg_addr_t rd_addr,
    output ooo_pkg::data_t     rd_data
);

    localparam int reg_count = 2 ** ooo_pkg::reg_addr_len;

    ooo_pkg::data_t regs [reg_count];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (commit_valid) begin
            regs[commit.rd] <= commit.data;  // Only retired results reach here.
        end
    end

    // r0 is hardwired to zero.
    assign rd_data = (rd_addr == '0) ? '0 : regs[rd_addr];

endmodule

// ==== verilog/ooo_core_top.sv ====
`timescale 1ns/1ps

module ooo_core_top #(
    parameter int rob_depth = 8,
    parameter int station_slots = 4
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               instr_valid,
    input  ooo_pkg::instr_t    instr,
    output logic               stall,
    output logic               commit_valid,
    output ooo_pkg::commit_t   commit,
    output logic               flush,
    input  ooo_pkg::reg_addr_t rd_addr,
    output ooo_pkg::data_t     rd_data
);

    logic            disp_fire;
    ooo_pkg::tag_t   disp_tag;
    ooo_pkg::instr_t disp_instr;
    ooo_pkg::tag_t   next_tag;
    logic            rob_full;
    logic            station_full;
    logic            cdb_valid;
    ooo_pkg::cdb_t   cdb;

    dispatch_unit #(
        .rob_depth(rob_depth)
    ) i_dispatch_unit (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .rob_full    (rob_full),
        .station_full(station_full),
        .flush       (flush),
        .next_tag    (next_tag),
        .stall       (stall),
        .disp_fire   (disp_fire),
        .disp_tag    (disp_tag),
        .disp_instr  (disp_instr)
    );

    exec_station #(
        .station_slots(station_slots)
    ) i_exec_station (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .disp_fire   (disp_fire),
        .disp_tag    (disp_tag),
        .disp_instr  (disp_instr),
        .station_full(station_full),
        .cdb_valid   (cdb_valid),
        .cdb         (cdb)
    );

    reorder_buffer #(
        .rob_depth(rob_depth)
    ) i_reorder_buffer (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .disp_fire   (disp_fire),
        .disp_tag    (disp_tag),
        .disp_instr  (disp_instr),
        .cdb_valid   (cdb_valid),
        .cdb         (cdb),
        .next_tag    (next_tag),
        .rob_full    (rob_full),
        .commit_valid(commit_valid),
        .commit      (commit)
    );

    arch_reg_file i_arch_reg_file (
        .clk         (clk),
        .rst         (rst),
        .commit_valid(commit_valid),
        .commit      (commit),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data)
    );

endmodule

// ==== dv/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int period_ns = 4,
    parameter int reset_cycles = 2
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #1 rst = 1'b0;  // Released with the same offset as the stimulus.
    end

endmodule

// ==== dv/ooo_tb.sv ====
`timescale 1ns/1ps

module ooo_tb;

    localparam int total_instr = 5 + 8 + 24 + 11 + 200;
    localparam int timeout_cycles = 40 * total_instr + 200;

    typedef struct packed {
        ooo_pkg::commit_t commit;
        logic             mispredict;
    } exp_t;

    logic               clk;
    logic               rst;
    logic               instr_valid;
    ooo_pkg::instr_t    instr;
    logic               stall;
    logic               commit_valid;
    ooo_pkg::commit_t   commit;
    logic               flush;
    ooo_pkg::reg_addr_t rd_addr;
    ooo_pkg::data_t     rd_data;

    exp_t           exp_q[$];
    ooo_pkg::data_t ref_regs [32];
    logic           squash;  // Set while younger work behind a mispredict is doomed.
    logic           stall_seen;
    int             errors;
    int             checks;
    int             test_no;
    int             test_errors;
    int             flush_cnt;
    int             cycles;

    tb_clock_gen i_tb_clock_gen (.clk(clk), .rst(rst));

    ooo_core_top #(
        .rob_depth(8),
        .station_slots(4)
    ) i_ooo_core_top (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .stall       (stall),
        .commit_valid(commit_valid),
        .commit      (commit),
        .flush       (flush),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data)
    );

    // Results follow the opcode rules; a branch is predicted not equal.
    function automatic exp_t model_instr(input ooo_pkg::instr_t ins);
        exp_t e;
        e.commit.rd = ins.rd;
        e.mispredict = 1'b0;
        case (ins.op)
            ooo_pkg::op_add: e.commit.data = ins.src_a + ins.src_b;
            ooo_pkg::op_sub: e.commit.data = ins.src_a - ins.src_b;
            ooo_pkg::op_xor: e.commit.data = ins.src_a ^ ins.src_b;
            default: begin
                e.mispredict = ins.src_a == ins.src_b;
                e.commit.data = e.mispredict ? 32'd1 : 32'd0;
            end
        endcase
        return e;
    endfunction

    function automatic ooo_pkg::instr_t make_instr(input ooo_pkg::op_e op, input int rd,
                                                   input ooo_pkg::data_t a, input ooo_pkg::data_t b);
        ooo_pkg::instr_t ins;
        ins.op = op;
        ins.rd = ooo_pkg::reg_addr_t'(rd);
        ins.src_a = a;
        ins.src_b = b;
        return ins;
    endfunction

    task automatic check_commit(input ooo_pkg::commit_t got, input ooo_pkg::commit_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: commit got r%0d=%h, expected r%0d=%h",
                     $time, got.rd, got.data, exp.rd, exp.data);
        end
    endtask

    task automatic check_data(input ooo_pkg::data_t got, input ooo_pkg::data_t exp, input int r);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: register r%0d reads %h, expected %h", $time, r, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: flush is %b on commit, expected %b", $time, got, exp);
        end
    endtask

    // Mid-cycle sampling keeps the compare clear of the clock edge.
    always @(negedge clk) begin
        exp_t e;
        if (!rst && commit_valid) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("Unexpected commit to r%0d with nothing outstanding", commit.rd);
            end else begin
                e = exp_q.pop_front();
                check_commit(commit, e.commit);
                check_flag(flush, e.mispredict);
            end
        end
        if (!rst && flush) begin
            flush_cnt++;
            squash = 1'b0;
        end
    end

    task automatic send_instr(input ooo_pkg::instr_t ins);
        exp_t e;
        while (stall) begin
            stall_seen = 1'b1;
            @(posedge clk);
            #1;
        end
        instr_valid = 1'b1;
        instr = ins;
        if (!squash) begin  // A squashed instruction never reaches the queue.
            e = model_instr(ins);
            exp_q.push_back(e);
            if (ins.rd != '0) ref_regs[ins.rd] = e.commit.data;
            if (e.mispredict) squash = 1'b1;
        end
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic drain_and_check_regs();
        while (exp_q.size() != 0) idle_cycles(1);
        idle_cycles(2);
        for (int r = 0; r < 32; r++) begin
            rd_addr = ooo_pkg::reg_addr_t'(r);
            #1;
            check_data(rd_data, ref_regs[r], r);
            idle_cycles(1);
        end
    endtask

    task automatic finish_test(input string name);
        test_no++;
        $display("Test %0d %s finished with %0d errors", test_no, name, errors - test_errors);
        test_errors = errors;
    endtask

    initial begin
        ooo_pkg::op_e   op;
        ooo_pkg::data_t a;
        ooo_pkg::data_t b;
        void'($urandom(32'h2eb456e6));
        instr_valid = 1'b0;
        instr = '0;
        rd_addr = '0;
        squash = 1'b0;
        stall_seen = 1'b0;
        {errors, checks, test_no, test_errors, flush_cnt} = '0;
        for (int r = 0; r < 32; r++) ref_regs[r] = '0;
        @(negedge rst);
        idle_cycles(1);

        send_instr(make_instr(ooo_pkg::op_add, 1, 32'd5, 32'd7));
        send_instr(make_instr(ooo_pkg::op_sub, 2, 32'd10, 32'd3));
        send_instr(make_instr(ooo_pkg::op_xor, 3, 32'hf0f0_1234, 32'h0ff0_4321));
        send_instr(make_instr(ooo_pkg::op_add, 0, 32'd1, 32'd1));  // r0 must stay zero.
        send_instr(make_instr(ooo_pkg::op_brc, 15, 32'd3, 32'd4));
        drain_and_check_regs();
        finish_test("single_ops");

        send_instr(make_instr(ooo_pkg::op_sub, 4, 32'd100, 32'd1));
        for (int i = 0; i < 7; i++) send_instr(make_instr(ooo_pkg::op_add, 5 + i, i, 32'd20));
        drain_and_check_regs();
        finish_test("out_of_order");

        stall_seen = 1'b0;
        for (int i = 0; i < 24; i++) begin
            op = (i % 4 == 3) ? ooo_pkg::op_add : ooo_pkg::op_sub;  // Subs pile up in the station.
            send_instr(make_instr(op, 1 + (i % 31), $urandom(), $urandom()));
        end
        drain_and_check_regs();
        if (!stall_seen) begin
            errors++;
            $display("Stall never rose during the long burst");
        end
        finish_test("fill_stall");

        for (int i = 0; i < 3; i++) send_instr(make_instr(ooo_pkg::op_add, 12 + i, i, 32'd50));
        drain_and_check_regs();
        send_instr(make_instr(ooo_pkg::op_brc, 11, 32'd42, 32'd42));
        for (int i = 0; i < 3; i++) send_instr(make_instr(ooo_pkg::op_xor, 12 + i, i, 32'hffff));
        drain_and_check_regs();
        if (flush_cnt == 0) begin
            errors++;
            $display("No flush was seen for the mispredicted branch");
        end
        for (int i = 0; i < 4; i++) send_instr(make_instr(ooo_pkg::op_sub, 12 + i, 32'd9, i));
        drain_and_check_regs();
        finish_test("mispredict_flush");

        for (int i = 0; i < 200; i++) begin
            op = ooo_pkg::op_e'(2'($urandom_range(0, 3)));
            a = $urandom();
            b = (op == ooo_pkg::op_brc && $urandom_range(0, 15) == 0) ? a : $urandom();
            send_instr(make_instr(op, $urandom_range(0, 31), a, b));
            idle_cycles($urandom_range(0, 2));
        end
        drain_and_check_regs();
        finish_test("random_programs");

        $display("Summary: %0d tests, %0d checks, %0d errors", test_no, checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin
        cycles = 0;
        while (cycles < timeout_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("Run stalled and hit the limit of %0d cycles", timeout_cycles);
        $display("test failed");
        $finish;
    end

endmodule

// ==== flist.f ====
verilog/ooo_pkg.sv
verilog/dispatch_unit.sv
verilog/exec_station.sv
verilog/reorder_buffer.sv
verilog/arch_reg_file.sv
verilog/ooo_core_top.sv
dv/tb_clock_gen.sv
dv/ooo_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root.
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing -f flist.f --top-module ooo_tb --Mdir obj_dir -o ooo_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/ooo_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "test passed" "$log"; then
    echo "Simulation result: pass"
    exit 0
else
    echo "Simulation result: fail"
    exit 1
fi
